/* design/monopix_macros.svh */
`ifndef MONOPIX_MACROS_SVH
`define MONOPIX_MACROS_SVH

// Matrix dimensions of the reduced periphery
`define NUM_FLAVORS 4
`define NUM_COLS 8

// Bunch crossing counter width, wraps at 64
`define BCID_WIDTH 6

// Flops on each configuration strobe before edge detection
`define CONF_SYNC_STAGES 2

// Serial chain length, matches the packed config word
`define CONF_WIDTH 22

`endif

/* design/monopixConfPkg.sv */
`include "monopix_macros.svh"

package monopixConfPkg;

    // Global configuration word, MSB first on the serial chain
    typedef struct packed {
        logic [`NUM_FLAVORS-1:0] enHitOrOut;  // Per-flavor hit-OR output enable
        logic [`NUM_COLS-1:0]    colPulseSel; // Columns receiving the injection pulse
        logic [`NUM_COLS-1:0]    digMonSel;   // Columns contributing to hit-OR
        logic                    injMonL;     // Left monitor injection
        logic                    injMonR;     // Right monitor injection
    } confWord_t;

    // Power-up word, all columns selected for monitoring but nothing driven out
    localparam confWord_t CONF_DEFAULT = '{
        enHitOrOut:  '0,
        colPulseSel: '0,
        digMonSel:   '1,
        injMonL:     1'b0,
        injMonR:     1'b0
    };

    // Sequencer states
    typedef enum logic [1:0] {
        CONF_IDLE,
        CONF_CLK_HIGH,      // Shift issued, waiting for clkConf low
        CONF_HOLD_DEFAULT   // defConf asserted
    } confState_t;

    // Operations executed by the configuration register
    typedef enum logic [1:0] {
        OP_NONE,
        OP_SHIFT,
        OP_LOAD,
        OP_DEFAULT
    } confOp_t;

endpackage

/* design/monopixMatrixPkg.sv */
`include "monopix_macros.svh"

package monopixMatrixPkg;

    // One bit per matrix column
    typedef logic [`NUM_COLS-1:0] colVec_t;

    // One bit per front-end flavor
    typedef logic [`NUM_FLAVORS-1:0] flavorVec_t;

    // Column monitor bits, indexed [flavor][column]
    typedef logic [`NUM_FLAVORS-1:0][`NUM_COLS-1:0] monMatrix_t;

    // Bunch crossing ID as distributed to the columns
    typedef logic [`BCID_WIDTH-1:0] bcid_t;

endpackage

/* design/confSequencer.sv */
`timescale 1ns/1ns
`include "monopix_macros.svh"

module confSequencer import monopixConfPkg::*; (
    input  logic    ClkBx,
    input  logic    reset_ff,
    input  logic    defConf,
    input  logic    clkConf,
    input  logic    ldConf,
    input  logic    siConf,
    output confOp_t confOp,
    output logic    shiftBit
);

    // Strobe bundle per stage is {siConf, defConf, ldConf, clkConf}
    logic [`CONF_SYNC_STAGES-1:0][3:0] syncFf;
    logic       clkSync;
    logic       ldSync;
    logic       defSync;
    logic       siSync;
    logic       ldPrev;
    logic       ldRise;
    confState_t state;
    confState_t stateNext;
    confOp_t    opNext;

    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            syncFf <= '0;
            ldPrev <= 1'b0;
        end else begin
            syncFf <= {syncFf[`CONF_SYNC_STAGES-2:0], {siConf, defConf, ldConf, clkConf}};
            ldPrev <= ldSync;
        end
    end

    assign {siSync, defSync, ldSync, clkSync} = syncFf[`CONF_SYNC_STAGES-1];
    assign ldRise = ldSync & ~ldPrev;

    always_comb begin
        stateNext = state;
        opNext    = OP_NONE;
        unique case (state)
            CONF_IDLE: begin
                if (defSync) begin
                    stateNext = CONF_HOLD_DEFAULT;
                    opNext    = OP_DEFAULT;
                end else if (clkSync) begin // Rising clkConf seen from idle
                    stateNext = CONF_CLK_HIGH;
                    opNext    = OP_SHIFT;
                end else if (ldRise) begin
                    opNext = OP_LOAD;
                end
            end
            CONF_CLK_HIGH: begin
                if (defSync) begin
                    stateNext = CONF_HOLD_DEFAULT;
                    opNext    = OP_DEFAULT;
                end else begin
                    if (!clkSync)
                        stateNext = CONF_IDLE; // Re-arm for the next shift
                    if (ldRise)
                        opNext = OP_LOAD;
                end
            end
            CONF_HOLD_DEFAULT: begin
                opNext = OP_DEFAULT; // Repeated for as long as defConf is high
                // A clkConf still high here must not count as a new edge
                if (!defSync)
                    stateNext = clkSync ? CONF_CLK_HIGH : CONF_IDLE;
            end
            default: stateNext = CONF_IDLE;
        endcase
    end

    // Reset parks the FSM in the default state so one OP_DEFAULT follows reset release
    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            state  <= CONF_HOLD_DEFAULT;
            confOp <= OP_NONE;
        end else begin
            state  <= stateNext;
            confOp <= opNext;
        end
    end

    always_ff @(posedge ClkBx)
        shiftBit <= siSync; // Aligned with confOp

endmodule

/* design/confRegister.sv */
`timescale 1ns/1ns
`include "monopix_macros.svh"

module confRegister import monopixConfPkg::*; (
    input  logic      ClkBx,
    input  logic      reset_ff,
    input  confOp_t   confOp,
    input  logic      shiftBit,
    output logic      soConf,
    output confWord_t conf
);

    // Serial chain, bit 0 receives the incoming data
    logic [`CONF_WIDTH-1:0] chain;

    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            chain <= CONF_DEFAULT;
            conf  <= CONF_DEFAULT;
        end else begin
            unique case (confOp)
                OP_SHIFT: begin
                    chain <= {chain[`CONF_WIDTH-2:0], shiftBit};
                end
                OP_LOAD: begin
                    conf <= confWord_t'(chain); // Shadow update, chain untouched
                end
                OP_DEFAULT: begin
                    chain <= CONF_DEFAULT;
                    conf  <= CONF_DEFAULT;
                end
                default: begin
                end
            endcase
        end
    end

    // Readback taps the far end of the chain
    assign soConf = chain[`CONF_WIDTH-1];

endmodule

/* design/bcidCounter.sv */
`timescale 1ns/1ns
`include "monopix_macros.svh"

module bcidCounter import monopixMatrixPkg::*; (
    input  logic  ClkBx,
    input  logic  reset_ff,
    input  logic  resetBcid,
    output bcid_t bcidGray
);

    logic  resetBcidFf; // Registered resync strobe
    bcid_t bcidBin;

    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            resetBcidFf <= 1'b0;
            bcidBin     <= '0;
        end else begin
            resetBcidFf <= resetBcid;
            if (resetBcidFf)
                bcidBin <= '0;
            else
                bcidBin <= bcidBin + 1'b1; // Natural wrap at 2**BCID_WIDTH
        end
    end

    // Gray code so the columns latch at most one changing bit
    assign bcidGray = bcidBin ^ (bcidBin >> 1);

endmodule

/* design/matrixPeriphery.sv */
`timescale 1ns/1ns
`include "monopix_macros.svh"

module matrixPeriphery
    import monopixConfPkg::*;
    import monopixMatrixPkg::*;
(
    input  logic       ClkBx,
    input  logic       reset_ff,
    input  logic       pulse,
    input  confWord_t  conf,
    input  monMatrix_t digMon,
    output colVec_t    injCol,
    output logic       injMonL,
    output logic       injMonR,
    output flavorVec_t hitOr
);

    colVec_t    injColNext;
    flavorVec_t hitOrNext;

    // Injection goes only to the selected columns
    assign injColNext = {`NUM_COLS{pulse}} & conf.colPulseSel;

    // Masked OR over columns, then the per-flavor output enable
    always_comb begin
        hitOrNext = '0;
        for (int f = 0; f < `NUM_FLAVORS; f++) begin
            hitOrNext[f] = (|(digMon[f] & conf.digMonSel)) & conf.enHitOrOut[f];
        end
    end

    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            injCol  <= '0;
            injMonL <= 1'b0;
            injMonR <= 1'b0;
            hitOr   <= '0;
        end else begin
            injCol  <= injColNext;
            injMonL <= pulse & conf.injMonL; // Monitor pixels at the matrix edges
            injMonR <= pulse & conf.injMonR;
            hitOr   <= hitOrNext;
        end
    end

endmodule

/* design/monopixPeriphery.sv */
`timescale 1ns/1ns
`include "monopix_macros.svh"

module monopixPeriphery
    import monopixConfPkg::*;
    import monopixMatrixPkg::*;
(
    input  logic       ClkBx,
    input  logic       reset_ff,
    input  logic       defConf,
    input  logic       clkConf,
    input  logic       ldConf,
    input  logic       siConf,
    input  logic       resetBcid,
    input  logic       pulse,
    input  monMatrix_t digMon,
    output logic       soConf,
    output logic       injMonL,
    output logic       injMonR,
    output colVec_t    injCol,
    output flavorVec_t hitOr,
    output bcid_t      bcidGray
);

    confOp_t   confOp;   // One-cycle register command
    logic      shiftBit;
    confWord_t conf;     // Active configuration

    confSequencer uSequencer (
        .ClkBx    (ClkBx),
        .reset_ff (reset_ff),
        .defConf  (defConf),
        .clkConf  (clkConf),
        .ldConf   (ldConf),
        .siConf   (siConf),
        .confOp   (confOp),
        .shiftBit (shiftBit)
    );

    confRegister uConfReg (
        .ClkBx    (ClkBx),
        .reset_ff (reset_ff),
        .confOp   (confOp),
        .shiftBit (shiftBit),
        .soConf   (soConf),
        .conf     (conf)
    );

    // Timestamp for the column readout
    bcidCounter uBcid (
        .ClkBx     (ClkBx),
        .reset_ff  (reset_ff),
        .resetBcid (resetBcid),
        .bcidGray  (bcidGray)
    );

    matrixPeriphery uMatrix (
        .ClkBx    (ClkBx),
        .reset_ff (reset_ff),
        .pulse    (pulse),
        .conf     (conf),
        .digMon   (digMon),
        .injCol   (injCol),
        .injMonL  (injMonL),
        .injMonR  (injMonR),
        .hitOr    (hitOr)
    );

endmodule

/* verif/tbMonopixPeriphery.sv */
`timescale 1ns/1ns
`include "monopix_macros.svh"

module tbMonopixPeriphery import monopixMatrixPkg::*; ();

    localparam int CW          = `CONF_WIDTH;
    localparam int CLK_PERIOD  = 20;
    localparam int HOLD_CYCLES = 6; // Minimum strobe level time

    // enHitOrOut, colPulseSel, digMonSel, injMonL, injMonR
    localparam logic [CW-1:0] DEFAULT_WORD = {4'h0, 8'h00, 8'hff, 1'b0, 1'b0};

    // Test lengths in strobe periods
    localparam int WORD_PERIODS   = CW * 3 + 2;
    localparam int READ_PERIODS   = CW * 3;
    localparam int MATRIX_PERIODS = 5;
    localparam int BCID_PERIODS   = 13;
    localparam int TOTAL_PERIODS  = 5 * WORD_PERIODS + 4 * READ_PERIODS
                                  + 6 * MATRIX_PERIODS + BCID_PERIODS + 3;
    localparam int TIMEOUT_NS     = TOTAL_PERIODS * HOLD_CYCLES * CLK_PERIOD * 3 / 2;

    logic       ClkBx;
    logic       reset_ff;
    logic       defConf;
    logic       clkConf;
    logic       ldConf;
    logic       siConf;
    logic       resetBcid;
    logic       pulse;
    monMatrix_t digMon;
    logic       soConf;
    logic       injMonL;
    logic       injMonR;
    colVec_t    injCol;
    flavorVec_t hitOr;
    bcid_t      bcidGray;

    int          errorCount = 0;
    int          checkCount = 0;
    int          testCount  = 0;
    logic [31:0] rngState   = 32'h4157_5405;

    monopixPeriphery dut (
        .ClkBx     (ClkBx),
        .reset_ff  (reset_ff),
        .defConf   (defConf),
        .clkConf   (clkConf),
        .ldConf    (ldConf),
        .siConf    (siConf),
        .resetBcid (resetBcid),
        .pulse     (pulse),
        .digMon    (digMon),
        .soConf    (soConf),
        .injMonL   (injMonL),
        .injMonR   (injMonR),
        .injCol    (injCol),
        .hitOr     (hitOr),
        .bcidGray  (bcidGray)
    );

    initial begin
        ClkBx = 1'b0;
        forever #(CLK_PERIOD / 2) ClkBx = ~ClkBx;
    end

    // Xorshift32
    function automatic logic [31:0] nextRand();
        logic [31:0] x;
        x = rngState;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rngState = x;
        return x;
    endfunction

    function automatic logic [CW-1:0] randWord();
        logic [31:0] r;
        r = nextRand();
        return r[CW-1:0];
    endfunction

    function automatic colVec_t colSelOf(input logic [CW-1:0] w);
        return w[2*`NUM_COLS+1 -: `NUM_COLS];
    endfunction

    // Per flavor OR over the selected columns, gated by its enable bit
    function automatic flavorVec_t expectedHitOr(input logic [CW-1:0] w, input monMatrix_t dm);
        flavorVec_t res;
        colVec_t    sel;
        logic       anyHit;
        sel = w[`NUM_COLS+1 -: `NUM_COLS];
        for (int f = 0; f < `NUM_FLAVORS; f++) begin
            anyHit = 1'b0;
            for (int c = 0; c < `NUM_COLS; c++) begin
                if (dm[f][c] && sel[c])
                    anyHit = 1'b1;
            end
            res[f] = anyHit && w[CW-`NUM_FLAVORS+f];
        end
        return res;
    endfunction

    function automatic bcid_t grayToBin(input bcid_t g);
        bcid_t b;
        b[`BCID_WIDTH-1] = g[`BCID_WIDTH-1];
        for (int i = `BCID_WIDTH-2; i >= 0; i--)
            b[i] = b[i+1] ^ g[i];
        return b;
    endfunction

    function automatic int onesCount(input bcid_t v);
        int n;
        n = 0;
        for (int i = 0; i < `BCID_WIDTH; i++) begin
            if (v[i])
                n++;
        end
        return n;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        checkCount++;
        if (got !== expected) begin
            errorCount++;
            $display("[FAIL] %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, expected);
        end
    endtask

    task automatic reportTest(input string name, input int errStart);
        testCount++;
        $display("[DONE] %s: %0d mismatches", name, errorCount - errStart);
    endtask

    task automatic waitCycles(input int n);
        repeat (n) @(negedge ClkBx);
    endtask

    // One serial bit, data set up well before the clkConf rise
    task automatic clockBit(input logic b);
        siConf = b;
        waitCycles(HOLD_CYCLES);
        clkConf = 1'b1;
        waitCycles(HOLD_CYCLES);
        clkConf = 1'b0;
        waitCycles(HOLD_CYCLES);
    endtask

    task automatic shiftWord(input logic [CW-1:0] w, input bit doLoad);
        for (int i = CW - 1; i >= 0; i--)
            clockBit(w[i]);
        if (doLoad) begin
            ldConf = 1'b1;
            waitCycles(HOLD_CYCLES);
            ldConf = 1'b0;
            waitCycles(HOLD_CYCLES);
        end
    endtask

    // Each bit read is shifted back in so the chain ends where it started
    task automatic readWord(output logic [CW-1:0] w);
        logic b;
        for (int i = CW - 1; i >= 0; i--) begin
            b    = soConf;
            w[i] = b;
            clockBit(b);
        end
    endtask

    // Back to back random inputs, each result checked one edge later
    task automatic matrixCycles(input logic [CW-1:0] word, input int cycles,
                                input bit drivePulse, input bit driveMon);
        colVec_t     expCol;
        logic        expL;
        logic        expR;
        flavorVec_t  expHit;
        logic [31:0] r;
        logic        p;
        monMatrix_t  dm;
        for (int k = 0; k <= cycles; k++) begin
            if (k > 0) begin
                @(negedge ClkBx);
                checkValue("injCol", 32'(injCol), 32'(expCol));
                checkValue("injMonL", 32'(injMonL), 32'(expL));
                checkValue("injMonR", 32'(injMonR), 32'(expR));
                checkValue("hitOr", 32'(hitOr), 32'(expHit));
            end
            if (k < cycles) begin
                r  = nextRand();
                p  = drivePulse && (r[0] || k == 0);
                dm = driveMon ? monMatrix_t'(nextRand()) : '0;
                pulse  = p;
                digMon = dm;
                expCol = p ? colSelOf(word) : '0;
                expL   = p && word[1];
                expR   = p && word[0];
                expHit = expectedHitOr(word, dm);
            end
        end
        pulse  = 1'b0;
        digMon = '0;
    endtask

    task automatic resetDefaults();
        int            errStart;
        logic [CW-1:0] rb;
        errStart = errorCount;
        readWord(rb);
        checkValue("soConf word", 32'(rb), 32'(DEFAULT_WORD));
        matrixCycles(DEFAULT_WORD, 8, 1'b1, 1'b1);
        reportTest("reset defaults", errStart);
    endtask

    task automatic loadAndReadback();
        int            errStart;
        logic [CW-1:0] w1;
        logic [CW-1:0] w2;
        logic [CW-1:0] rb;
        errStart = errorCount;
        w1 = randWord();
        shiftWord(w1, 1'b1);
        readWord(rb);
        checkValue("soConf word", 32'(rb), 32'(w1));
        w2 = randWord();
        shiftWord(w2, 1'b0); // Chain only, shadow keeps w1
        matrixCycles(w1, 16, 1'b1, 1'b1);
        readWord(rb);
        checkValue("soConf word", 32'(rb), 32'(w2));
        reportTest("load and readback", errStart);
    endtask

    task automatic injectionGating();
        int            errStart;
        logic [CW-1:0] w;
        errStart = errorCount;
        w = randWord();
        shiftWord(w, 1'b1);
        matrixCycles(w, 24, 1'b1, 1'b0);
        reportTest("injection gating", errStart);
    endtask

    task automatic hitOrReduction();
        int            errStart;
        logic [CW-1:0] w;
        errStart = errorCount;
        w = randWord();
        shiftWord(w, 1'b1);
        matrixCycles(w, 24, 1'b0, 1'b1);
        reportTest("hit-or reduction", errStart);
    endtask

    task automatic bcidSequence();
        int    errStart;
        bcid_t prevGray;
        bcid_t curGray;
        bcid_t expCount;
        errStart  = errorCount;
        resetBcid = 1'b1;
        @(negedge ClkBx);
        resetBcid = 1'b0;
        @(negedge ClkBx);
        checkValue("bcidGray", 32'(bcidGray), 32'(0));
        prevGray = bcidGray;
        expCount = '0;
        for (int i = 0; i < 70; i++) begin // Runs through the wrap at 64
            @(negedge ClkBx);
            curGray  = bcidGray;
            expCount = expCount + bcid_t'(1);
            checkValue("bcidGray changed bits", 32'(onesCount(prevGray ^ curGray)), 32'(1));
            checkValue("bcidGray decoded", 32'(grayToBin(curGray)), 32'(expCount));
            prevGray = curGray;
        end
        reportTest("bcid sequence", errStart);
    endtask

    task automatic defaultRestore();
        int            errStart;
        logic [CW-1:0] w;
        logic [CW-1:0] rb;
        errStart = errorCount;
        w = randWord();
        w[CW-1:2*`NUM_COLS+2] = '1; // All flavors enabled
        w[2*`NUM_COLS+1 -: `NUM_COLS] = '1;
        shiftWord(w, 1'b1);
        matrixCycles(w, 4, 1'b1, 1'b1);
        defConf = 1'b1;
        waitCycles(HOLD_CYCLES);
        defConf = 1'b0;
        waitCycles(HOLD_CYCLES);
        matrixCycles(DEFAULT_WORD, 8, 1'b1, 1'b1);
        readWord(rb);
        checkValue("soConf word", 32'(rb), 32'(DEFAULT_WORD));
        reportTest("default restore", errStart);
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog: the tests did not finish within %0d ns, the DUT appears hung",
                 TIMEOUT_NS);
        $display("Test failed");
        $finish;
    end

    initial begin
        reset_ff  = 1'b1;
        defConf   = 1'b0;
        clkConf   = 1'b0;
        ldConf    = 1'b0;
        siConf    = 1'b0;
        resetBcid = 1'b0;
        pulse     = 1'b0;
        digMon    = '0;
        waitCycles(3);
        reset_ff = 1'b0;
        waitCycles(2);

        resetDefaults();
        loadAndReadback();
        injectionGating();
        hitOrReduction();
        bcidSequence();
        defaultRestore();

        $display("Summary: %0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* monopixPeriphery.f */
+incdir+design
design/monopixConfPkg.sv
design/monopixMatrixPkg.sv
design/confSequencer.sv
design/confRegister.sv
design/bcidCounter.sv
design/matrixPeriphery.sv
design/monopixPeriphery.sv
verif/tbMonopixPeriphery.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the periphery testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --timescale 1ns/1ns -Wno-fatal \
    --top-module tbMonopixPeriphery \
    -f monopixPeriphery.f \
    -Mdir "$OBJ"
if [ $? -ne 0 ]; then
    echo "Verilator compile step failed"
    exit 1
fi

"./$OBJ/VtbMonopixPeriphery" > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "Test failed" "$LOG"; then
    echo "Simulation reported a failure, see $LOG"
    exit 1
fi

if ! grep -q "Test passed" "$LOG"; then
    echo "Simulation ended without a result line, see $LOG"
    exit 1
fi

echo "Simulation finished cleanly"
exit 0
